/* lsu_core.f */
hdl/lsu_pkg.sv
hdl/store_format.sv
hdl/data_ram.sv
hdl/load_align.sv
hdl/mem_writeback.sv
hdl/lsu_top.sv
bench/tb_clock.sv
bench/lsu_checker.sv
bench/lsu_monitor.sv
bench/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu_core

sources:
  - files:
      - hdl/lsu_pkg.sv
      - hdl/store_format.sv
      - hdl/data_ram.sv
      - hdl/load_align.sv
      - hdl/mem_writeback.sv
      - hdl/lsu_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/lsu_checker.sv
      - bench/lsu_monitor.sv
      - bench/lsu_tb.sv

/* bench/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;

    typedef struct packed {
        ls_sel_e     sel;
        logic [31:0] addr;
        logic [31:0] rt;
        logic        wena;
        logic        prior;
        logic        adel;
        logic        ades;
    } entry_t;

    logic       clk;
    logic       rst;
    ls_req_t    req;
    wb_result_t result;
    logic       adel;
    logic       ades;
    logic       exp_adel;
    logic       exp_ades;
    int         value_errors;
    int         seq_errors;
    int         pending;
    int         n_entries = 0;

    entry_t      entries [$];
    logic [31:0] lfsr_state = 32'h6462;

    tb_clock u_clock (
        .clk (clk)
    );

    lsu_top uut (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .result (result),
        .adel   (adel),
        .ades   (ades)
    );

    lsu_monitor u_monitor (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .exp_adel     (exp_adel),
        .exp_ades     (exp_ades),
        .adel         (adel),
        .ades         (ades),
        .result       (result),
        .value_errors (value_errors),
        .seq_errors   (seq_errors),
        .pending      (pending)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one LFSR step per bit
    task automatic rand_word(output logic [31:0] w);
        int b;
        for (b = 0; b < 32; b++) begin
            w[b]       = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic add_entry(input ls_sel_e sel, input logic [31:0] addr,
                             input logic [31:0] rt, input logic wena, input logic prior,
                             input logic adel_e, input logic ades_e);
        entry_t e;
        e.sel   = sel;
        e.addr  = addr;
        e.rt    = rt;
        e.wena  = wena;
        e.prior = prior;
        e.adel  = adel_e;
        e.ades  = ades_e;
        entries.push_back(e);
    endtask

    task automatic add_store(input ls_sel_e sel, input logic [31:0] addr,
                             input logic [31:0] rt);
        add_entry(sel, addr, rt, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic add_load(input ls_sel_e sel, input logic [31:0] addr,
                            input logic [31:0] rt);
        add_entry(sel, addr, rt, 1'b1, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic build_table();
        logic [31:0] r;
        int          k;
        add_store(LS_SW, 32'h10, 32'hCAFE_F00D);
        for (k = 0; k < 4; k++) begin
            rand_word(r);
            add_store(LS_SB, 32'h10 + k, r);
            add_load(LS_LW, 32'h10, 32'h0);
        end
        add_store(LS_SW, 32'h14, 32'h0F1E_2D3C);
        for (k = 0; k < 4; k += 2) begin
            rand_word(r);
            add_store(LS_SH, 32'h14 + k, r);
            add_load(LS_LW, 32'h14, 32'h0);
        end
        rand_word(r);
        add_store(LS_SW, 32'h18, r);
        add_load(LS_LW, 32'h18, 32'h0);
        // mixed sign bytes and halves for the extension cases
        add_store(LS_SW, 32'h20, 32'h80F1_7F05);
        for (k = 0; k < 4; k++) begin
            add_load(LS_LB, 32'h20 + k, 32'h0);
            add_load(LS_LBU, 32'h20 + k, 32'h0);
        end
        for (k = 0; k < 4; k += 2) begin
            add_load(LS_LH, 32'h20 + k, 32'h0);
            add_load(LS_LHU, 32'h20 + k, 32'h0);
        end
        for (k = 0; k < 4; k++) begin
            add_store(LS_SW, 32'h40 + 4 * k, 32'h1122_3344);
            rand_word(r);
            add_store(LS_SWL, 32'h40 + 5 * k, r);
            add_load(LS_LW, 32'h40 + 4 * k, 32'h0);
            add_store(LS_SW, 32'h50 + 4 * k, 32'h5566_7788);
            rand_word(r);
            add_store(LS_SWR, 32'h50 + 5 * k, r);
            add_load(LS_LW, 32'h50 + 4 * k, 32'h0);
        end
        for (k = 0; k < 4; k++) begin
            add_load(LS_LWL, 32'h20 + k, 32'hA5A5_5A5A);
            add_load(LS_LWR, 32'h20 + k, 32'h5A5A_A5A5);
        end
        // misaligned accesses must leave the word alone
        add_store(LS_SW, 32'h60, 32'h0BAD_BEEF);
        rand_word(r);
        add_entry(LS_SH, 32'h61, r, 1'b0, 1'b0, 1'b0, 1'b1);
        add_entry(LS_SW, 32'h62, r, 1'b0, 1'b0, 1'b0, 1'b1);
        add_entry(LS_SW, 32'h63, r, 1'b0, 1'b0, 1'b0, 1'b1);
        add_entry(LS_LH, 32'h61, 32'h0, 1'b1, 1'b0, 1'b1, 1'b0);
        add_entry(LS_LHU, 32'h63, 32'h0, 1'b1, 1'b0, 1'b1, 1'b0);
        add_entry(LS_LW, 32'h62, 32'h0, 1'b1, 1'b0, 1'b1, 1'b0);
        add_load(LS_LW, 32'h60, 32'h0);
        add_store(LS_SW, 32'h64, 32'h1357_9BDF);
        rand_word(r);
        add_entry(LS_SW, 32'h64, r, 1'b0, 1'b1, 1'b0, 1'b0);
        add_load(LS_LW, 32'h64, 32'h0);
        add_entry(LS_LW, 32'h64, 32'h0, 1'b1, 1'b1, 1'b0, 1'b0);
        add_entry(LS_LH, 32'h65, 32'h0, 1'b1, 1'b1, 1'b1, 1'b0);
        add_entry(LS_NONE, 32'h1234_5678, 32'hFFFF_FFFF, 1'b1, 1'b0, 1'b0, 1'b0);
        add_entry(LS_NONE, 32'h8765_4321, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    initial begin
        int i;
        int asserts;
        rst      = 1'b1;
        req      = '0;
        exp_adel = 1'b0;
        exp_ades = 1'b0;
        build_table();
        n_entries = entries.size();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (i = 0; i < n_entries; i++) begin
            @(posedge clk);
            #1;
            req.valid     = 1'b1;
            req.sel       = entries[i].sel;
            req.addr      = entries[i].addr;
            req.rt_data   = entries[i].rt;
            req.w_reg_ena = entries[i].wena;
            req.w_reg_dst = i[4:0];
            req.prior_exc = entries[i].prior;
            exp_adel      = entries[i].adel;
            exp_ades      = entries[i].ades;
        end
        @(posedge clk);
        #1;
        req      = '0;
        exp_adel = 1'b0;
        exp_ades = 1'b0;
        wait (pending == 0);
        repeat (2) @(posedge clk);
        asserts = uut.u_lsu_checker.fail_count;
        $display("errors: value %0d, sequence %0d, assertion %0d",
                 value_errors, seq_errors, asserts);
        if (value_errors + seq_errors + asserts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        wait (n_entries > 0);
        #((n_entries + 20) * 4);
        $display("timeout: the results did not drain before the time limit");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* bench/lsu_monitor.sv */
`timescale 1ns/1ps

module lsu_monitor (
    input  logic                clk,
    input  logic                rst,
    input  lsu_pkg::ls_req_t    req,
    input  logic                exp_adel,
    input  logic                exp_ades,
    input  logic                adel,
    input  logic                ades,
    input  lsu_pkg::wb_result_t result,
    output int                  value_errors,
    output int                  seq_errors,
    output int                  pending
);
    import lsu_pkg::*;

    typedef struct packed {
        wb_result_t  res;
        logic [31:0] due;
    } expect_t;

    // byte image of the 256-word RAM
    logic [7:0] model [1024];
    expect_t    exp_q [$];
    int         cyc = 0;

    initial begin
        value_errors = 0;
        seq_errors   = 0;
        pending      = 0;
    end

    function automatic logic misaligned(ls_sel_e sel, logic [1:0] k);
        case (sel)
            LS_LH, LS_LHU, LS_SH: return k[0];
            LS_LW, LS_SW:         return |k;
            default:              return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] model_word(logic [31:0] addr);
        logic [9:0] base;
        base = {addr[9:2], 2'b00};
        return {model[base+3], model[base+2], model[base+1], model[base]};
    endfunction

    task automatic compare_field(input string name, input logic [31:0] expv,
                                 input logic [31:0] got);
        if (got !== expv) begin
            value_errors++;
            $display("CHECK FAILED %s expected %h got %h", name, expv, got);
        end
    endtask

    // predicts the result by the lane rules and applies stores to the model
    task automatic predict(input ls_req_t r, output wb_result_t e);
        logic [9:0]  base;
        logic [31:0] w;
        logic [31:0] d;
        logic [31:0] rt;
        logic        load;
        logic        store;
        exc_e        x;
        int          k;
        int          j;
        k     = r.addr[1:0];
        base  = {r.addr[9:2], 2'b00};
        w     = model_word(r.addr);
        rt    = r.rt_data;
        load  = r.sel inside {LS_LB, LS_LBU, LS_LH, LS_LHU, LS_LW, LS_LWL, LS_LWR};
        store = r.sel inside {LS_SB, LS_SH, LS_SW, LS_SWL, LS_SWR};
        x     = EXC_NONE;
        if (r.prior_exc) begin
            x = EXC_PRIOR;
        end else if (load && misaligned(r.sel, r.addr[1:0])) begin
            x = EXC_ADEL;
        end else if (store && misaligned(r.sel, r.addr[1:0])) begin
            x = EXC_ADES;
        end
        d = 32'h0;
        if (x == EXC_NONE) begin
            case (r.sel)
                LS_LB:  d = {{24{w[8*k+7]}}, w[8*k +: 8]};
                LS_LBU: d = {24'h0, w[8*k +: 8]};
                LS_LH:  d = {{16{w[8*k+15]}}, w[8*k +: 16]};
                LS_LHU: d = {16'h0, w[8*k +: 16]};
                LS_LW:  d = w;
                LS_LWL: begin
                    d = rt;
                    for (j = 0; j <= k; j++) d[8*(3-k+j) +: 8] = w[8*j +: 8];
                end
                LS_LWR: begin
                    d = rt;
                    for (j = k; j < 4; j++) d[8*(j-k) +: 8] = w[8*j +: 8];
                end
                LS_SB: model[base+k] = rt[7:0];
                LS_SH: begin
                    model[base+k]   = rt[7:0];
                    model[base+k+1] = rt[15:8];
                end
                LS_SW: begin
                    for (j = 0; j < 4; j++) model[base+j] = rt[8*j +: 8];
                end
                LS_SWL: begin
                    for (j = 0; j <= k; j++) model[base+j] = rt[8*(3-k+j) +: 8];
                end
                LS_SWR: begin
                    for (j = k; j < 4; j++) model[base+j] = rt[8*(j-k) +: 8];
                end
                default: ;
            endcase
        end
        if (!load && !store) begin
            d = r.addr;
        end
        e.valid     = 1'b1;
        e.w_reg_ena = r.w_reg_ena & (x == EXC_NONE);
        e.w_reg_dst = r.w_reg_dst;
        e.wdata     = d;
        e.exc       = x;
    endtask

    // requests are sampled mid-cycle and taken at the next edge
    always @(negedge clk) begin
        wb_result_t e;
        expect_t    item;
        cyc++;
        if (!rst) begin
            if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
                item = exp_q.pop_front();
                if (!result.valid) begin
                    seq_errors++;
                    $display("missing result for the request due in cycle %0d", cyc);
                end else begin
                    compare_field("result.wdata", item.res.wdata, result.wdata);
                    compare_field("result.w_reg_ena", item.res.w_reg_ena, result.w_reg_ena);
                    compare_field("result.w_reg_dst", item.res.w_reg_dst, result.w_reg_dst);
                    compare_field("result.exc", item.res.exc, result.exc);
                end
            end else if (result.valid) begin
                seq_errors++;
                $display("unexpected result in cycle %0d with no request behind it", cyc);
            end
            if (req.valid) begin
                compare_field("adel", exp_adel, adel);
                compare_field("ades", exp_ades, ades);
                predict(req, e);
                item.res = e;
                item.due = cyc + 2;
                exp_q.push_back(item);
            end
        end
        pending = exp_q.size();
    end

endmodule

/* bench/lsu_checker.sv */
`timescale 1ns/1ps

module lsu_checker (
    input logic                clk,
    input logic                rst,
    input lsu_pkg::ram_cmd_t   ram_cmd,
    input lsu_pkg::wb_result_t result
);

    int fail_count = 0;

    // lanes are only written as part of an enabled access
    wen_needs_en: assert property (@(posedge clk) disable iff (rst)
        (ram_cmd.wen != 4'b0000) |-> ram_cmd.en)
        else begin
            $error("RAM write enable set while RAM disabled");
            fail_count++;
        end

    ena_needs_valid: assert property (@(posedge clk) disable iff (rst)
        result.w_reg_ena |-> result.valid)
        else begin
            $error("register write without a valid result");
            fail_count++;
        end

    reset_clears_valid: assert property (@(posedge clk) rst |=> !result.valid)
        else begin
            $error("result valid right after reset");
            fail_count++;
        end

endmodule

bind lsu_top lsu_checker u_lsu_checker (
    .clk     (clk),
    .rst     (rst),
    .ram_cmd (ram_cmd),
    .result  (result)
);

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

/* hdl/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top (
    input  logic                clk,
    input  logic                rst,
    input  lsu_pkg::ls_req_t    req,
    output lsu_pkg::wb_result_t result,
    output logic                adel,
    output logic                ades
);
    import lsu_pkg::*;

    ram_cmd_t          ram_cmd;
    logic [DATA_W-1:0] rdata;
    exc_e              exc_req;
    ls_req_t           stage;
    exc_e              stage_exc;
    logic [DATA_W-1:0] aligned;

    // request side, current instruction
    store_format u_store_format (
        .req     (req),
        .ram_cmd (ram_cmd),
        .exc_req (exc_req),
        .adel    (adel),
        .ades    (ades)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .ram_cmd (ram_cmd),
        .rdata   (rdata)
    );

    // response side, previous instruction
    load_align u_load_align (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .exc_req   (exc_req),
        .rdata     (rdata),
        .stage     (stage),
        .stage_exc (stage_exc),
        .aligned   (aligned)
    );

    mem_writeback u_mem_writeback (
        .clk       (clk),
        .rst       (rst),
        .stage     (stage),
        .stage_exc (stage_exc),
        .aligned   (aligned),
        .result    (result)
    );

endmodule

/* hdl/mem_writeback.sv */
`timescale 1ns/1ps

module mem_writeback (
    input  logic                clk,
    input  logic                rst,
    input  lsu_pkg::ls_req_t    stage,
    input  lsu_pkg::exc_e       stage_exc,
    input  logic [31:0]         aligned,
    output lsu_pkg::wb_result_t result
);
    import lsu_pkg::*;

    wb_result_t nxt;
    logic       has_exc;

    assign has_exc = (stage_exc != EXC_NONE);

    always_comb begin
        nxt.valid     = stage.valid;
        nxt.w_reg_ena = stage.valid & stage.w_reg_ena & ~has_exc;
        nxt.w_reg_dst = stage.w_reg_dst;
        nxt.exc       = stage.valid ? stage_exc : EXC_NONE;

        // a faulting load never reached the RAM, so it returns zero
        if (is_load(stage.sel)) begin
            nxt.wdata = has_exc ? '0 : aligned;
        end else if (is_store(stage.sel)) begin
            nxt.wdata = '0;
        end else begin
            nxt.wdata = stage.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else begin
            result <= nxt;
        end
    end

endmodule

/* hdl/load_align.sv */
`timescale 1ns/1ps

module load_align (
    input  logic             clk,
    input  logic             rst,
    input  lsu_pkg::ls_req_t req,
    input  lsu_pkg::exc_e    exc_req,
    input  logic [31:0]      rdata,
    output lsu_pkg::ls_req_t stage,
    output lsu_pkg::exc_e    stage_exc,
    output logic [31:0]      aligned
);
    import lsu_pkg::*;

    logic [1:0]        off;
    logic [7:0]        byte_sel;
    logic [15:0]       half_sel;
    logic [DATA_W-1:0] rt;

    // execute to memory stage register, rst clears the control fields
    always_ff @(posedge clk) begin
        stage     <= req;
        stage_exc <= exc_req;
        if (rst) begin
            stage.valid     <= 1'b0;
            stage.sel       <= LS_NONE;
            stage.w_reg_ena <= 1'b0;
            stage_exc       <= EXC_NONE;
        end
    end

    assign off      = stage.addr[1:0];
    assign rt       = stage.rt_data;
    assign byte_sel = rdata[8*off +: 8];
    assign half_sel = off[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (stage.sel)
            LS_LB:  aligned = {{24{byte_sel[7]}}, byte_sel};
            LS_LBU: aligned = {24'h0, byte_sel};
            LS_LH:  aligned = {{16{half_sel[15]}}, half_sel};
            LS_LHU: aligned = {16'h0, half_sel};
            LS_LW:  aligned = rdata;
            // lwl puts the low k+1 memory bytes at the top of rt
            LS_LWL: begin
                case (off)
                    2'd0:    aligned = {rdata[7:0], rt[23:0]};
                    2'd1:    aligned = {rdata[15:0], rt[15:0]};
                    2'd2:    aligned = {rdata[23:0], rt[7:0]};
                    default: aligned = rdata;
                endcase
            end
            // lwr puts the high 4-k memory bytes at the bottom of rt
            LS_LWR: begin
                case (off)
                    2'd0:    aligned = rdata;
                    2'd1:    aligned = {rt[31:24], rdata[31:8]};
                    2'd2:    aligned = {rt[31:16], rdata[31:16]};
                    default: aligned = {rt[31:8], rdata[31:24]};
                endcase
            end
            default: aligned = 32'h0;
        endcase
    end

endmodule

/* hdl/data_ram.sv */
`timescale 1ns/1ps

module data_ram (
    input  logic              clk,
    input  lsu_pkg::ram_cmd_t ram_cmd,
    output logic [31:0]       rdata
);
    import lsu_pkg::*;

    logic [DATA_W-1:0]     mem [2**RAM_ADDR_W];
    logic [RAM_ADDR_W-1:0] word_idx;

    // byte address to word index
    assign word_idx = ram_cmd.addr[RAM_ADDR_W+1:2];

    always_ff @(posedge clk) begin
        if (ram_cmd.en) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (ram_cmd.wen[lane]) begin
                    mem[word_idx][8*lane +: 8] <= ram_cmd.wdata[8*lane +: 8];
                end
            end
        end
    end

    // read returns the word as it was before this edge's write
    always_ff @(posedge clk) begin
        if (ram_cmd.en) begin
            rdata <= mem[word_idx];
        end
    end

endmodule

/* hdl/store_format.sv */
`timescale 1ns/1ps

module store_format (
    input  lsu_pkg::ls_req_t  req,
    output lsu_pkg::ram_cmd_t ram_cmd,
    output lsu_pkg::exc_e     exc_req,
    output logic              adel,
    output logic              ades
);
    import lsu_pkg::*;

    logic [1:0]        off;
    logic              mem_op;
    logic [3:0]        wen_raw;
    logic [DATA_W-1:0] wdata_raw;

    assign off    = req.addr[1:0];
    assign mem_op = is_load(req.sel) | is_store(req.sel);

    // halfword needs bit 0 clear, word needs both low bits clear
    assign adel = req.valid & (
        ((req.sel == LS_LH) | (req.sel == LS_LHU)) & off[0] |
        (req.sel == LS_LW) & (|off));

    assign ades = req.valid & (
        (req.sel == LS_SH) & off[0] |
        (req.sel == LS_SW) & (|off));

    always_comb begin
        if (!req.valid) begin
            exc_req = EXC_NONE;
        end else if (req.prior_exc) begin
            exc_req = EXC_PRIOR;
        end else if (adel) begin
            exc_req = EXC_ADEL;
        end else if (ades) begin
            exc_req = EXC_ADES;
        end else begin
            exc_req = EXC_NONE;
        end
    end

    always_comb begin
        wen_raw   = 4'b0000;
        wdata_raw = '0;
        case (req.sel)
            LS_SB: begin
                wen_raw   = 4'b0001 << off;
                wdata_raw = {4{req.rt_data[7:0]}};
            end
            LS_SH: begin
                wen_raw   = off[1] ? 4'b1100 : 4'b0011;
                wdata_raw = {2{req.rt_data[15:0]}};
            end
            LS_SW: begin
                wen_raw   = 4'b1111;
                wdata_raw = req.rt_data;
            end
            // swl at offset k fills lanes 0..k from the top of rt
            LS_SWL: begin
                wen_raw   = 4'b1111 >> (2'd3 - off);
                wdata_raw = req.rt_data >> (8 * (3 - off));
            end
            // swr at offset k fills lanes k..3 from the bottom of rt
            LS_SWR: begin
                wen_raw   = 4'b1111 << off;
                wdata_raw = req.rt_data << (8 * off);
            end
            default: begin
                wen_raw   = 4'b0000;
                wdata_raw = '0;
            end
        endcase
    end

    // no access at all once any exception is known
    assign ram_cmd.en    = req.valid & mem_op & (exc_req == EXC_NONE);
    assign ram_cmd.wen   = {4{ram_cmd.en}} & wen_raw;
    assign ram_cmd.addr  = {DATA_W{ram_cmd.en}} & req.addr;
    assign ram_cmd.wdata = wdata_raw;

endmodule

/* hdl/lsu_pkg.sv */
package lsu_pkg;

    localparam int RAM_ADDR_W = 8;
    localparam int DATA_W     = 32;

    typedef enum logic [3:0] {
        LS_NONE,
        LS_LB,
        LS_LBU,
        LS_LH,
        LS_LHU,
        LS_LW,
        LS_LWL,
        LS_LWR,
        LS_SB,
        LS_SH,
        LS_SW,
        LS_SWL,
        LS_SWR
    } ls_sel_e;

    // EXC_PRIOR marks an exception raised before the memory stage
    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_ADEL,
        EXC_ADES,
        EXC_PRIOR
    } exc_e;

    typedef struct packed {
        logic              valid;
        ls_sel_e           sel;
        logic [DATA_W-1:0] addr;
        logic [DATA_W-1:0] rt_data;
        logic              w_reg_ena;
        logic [4:0]        w_reg_dst;
        logic              prior_exc;
    } ls_req_t;

    typedef struct packed {
        logic              valid;
        logic              w_reg_ena;
        logic [4:0]        w_reg_dst;
        logic [DATA_W-1:0] wdata;
        exc_e              exc;
    } wb_result_t;

    typedef struct packed {
        logic              en;
        logic [3:0]        wen;
        logic [DATA_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } ram_cmd_t;

    function automatic logic is_load(ls_sel_e sel);
        return sel inside {LS_LB, LS_LBU, LS_LH, LS_LHU, LS_LW, LS_LWL, LS_LWR};
    endfunction

    function automatic logic is_store(ls_sel_e sel);
        return sel inside {LS_SB, LS_SH, LS_SW, LS_SWL, LS_SWR};
    endfunction

endpackage
